/* tinyrv2_l15_pkg.sv */
// --------------------
// shared widths, field positions, L1.5 codes and enums
// for the tinyrv2 to L1.5 bridge
// --------------------
`default_nettype none

package tinyrv2_l15_pkg;

    // core request message: type, addr, len, data from the top
    localparam int REQ_MSG_W    = 67;
    localparam int REQ_TYPE_BIT = 66;
    localparam int REQ_ADDR_HI  = 65;
    localparam int REQ_ADDR_LO  = 34;
    localparam int REQ_LEN_HI   = 33;
    localparam int REQ_LEN_LO   = 32;

    // core response message: type, len, data from the top
    localparam int RESP_MSG_W = 35;

    // L1.5 physical address width
    localparam int PHY_ADDR_W = 40;

    // interrupt code in bits 17:16 of the first return word
    localparam logic [1:0] WAKEUP_CODE = 2'd1;

    // addi x0, x0, 0
    localparam logic [31:0] NOP_INSN = 32'h0000_0013;

    // access length as encoded by the core
    typedef enum logic [1:0] {
        WORD = 2'd0,
        BYTE = 2'd1,
        HALF = 2'd2
    } mem_len_e;

    typedef enum logic [4:0] {
        LOAD_RQ  = 5'd0,
        STORE_RQ = 5'd1
    } l15_rqtype_e;

    typedef enum logic [3:0] {
        LOAD_RET = 4'd0,
        ST_ACK   = 4'd4,
        INT_RET  = 4'd7
    } l15_rettype_e;

    typedef enum logic [2:0] {
        SZ_1B = 3'd0,
        SZ_2B = 3'd1,
        SZ_4B = 3'd2
    } pcx_size_e;

    typedef enum logic {
        DATA_PORT = 1'b0,
        INSN_PORT = 1'b1
    } port_sel_e;

    // controller states
    typedef enum logic [2:0] {
        SLEEP,
        READY,
        ISSUE,
        WAIT_RESP,
        RESPOND
    } ctrl_state_e;

    // core is little endian, L1.5 is big endian
    function automatic logic [31:0] bswap32(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

endpackage

`default_nettype wire

/* tinyrv2_l15_ctrl.sv */
// --------------------
// bridge controller: wakeup, data-first arbitration,
// L1.5 issue, wait for return and core response handshake
// --------------------
`default_nettype none

module tinyrv2_l15_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,

    // core request and response handshakes
    input  logic                          imemreq_val,
    input  logic                          dmemreq_val,
    input  logic                          imemresp_rdy,
    input  logic                          dmemresp_rdy,
    output logic                          imemreq_rdy,
    output logic                          dmemreq_rdy,
    output logic                          imemresp_val,
    output logic                          dmemresp_val,

    // L1.5 request handshake
    input  logic                          l15_ack,
    output logic                          l15_val,

    // from the return decoder
    input  logic                          resp_arrive,
    input  logic                          wakeup,

    // to the datapath
    output logic                          capture_en,
    output tinyrv2_l15_pkg::port_sel_e    capture_sel,
    output logic                          resp_load,
    output tinyrv2_l15_pkg::port_sel_e    cur_port
);

    tinyrv2_l15_pkg::ctrl_state_e state;

    logic d_accept;
    logic i_accept;
    logic accept;
    logic resp_done;

    // rdy is only ever high in READY, so these are the accept edges
    assign d_accept = dmemreq_val && dmemreq_rdy;
    assign i_accept = imemreq_val && imemreq_rdy;
    assign accept   = d_accept || i_accept;

    // data port wins when both are valid
    assign capture_en  = accept;
    assign capture_sel = d_accept ? tinyrv2_l15_pkg::DATA_PORT : tinyrv2_l15_pkg::INSN_PORT;

    // register the response only while we expect one
    assign resp_load = (state == tinyrv2_l15_pkg::WAIT_RESP) && resp_arrive;

    // only the port that asked has its valid up
    assign resp_done = (imemresp_val && imemresp_rdy) || (dmemresp_val && dmemresp_rdy);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= tinyrv2_l15_pkg::SLEEP;
            imemreq_rdy  <= 1'b0;
            dmemreq_rdy  <= 1'b0;
            l15_val      <= 1'b0;
            cur_port     <= tinyrv2_l15_pkg::DATA_PORT;
            imemresp_val <= 1'b0;
            dmemresp_val <= 1'b0;
        end else begin
            case (state)
                // refuse everything until the wakeup interrupt
                tinyrv2_l15_pkg::SLEEP: begin
                    if (wakeup) begin
                        state       <= tinyrv2_l15_pkg::READY;
                        imemreq_rdy <= 1'b1;
                        dmemreq_rdy <= 1'b1;
                    end
                end
                tinyrv2_l15_pkg::READY: begin
                    if (accept) begin
                        state       <= tinyrv2_l15_pkg::ISSUE;
                        imemreq_rdy <= 1'b0;
                        dmemreq_rdy <= 1'b0;
                        l15_val     <= 1'b1;
                        cur_port    <= capture_sel;
                    end
                end
                // level valid, held until the cache acks
                tinyrv2_l15_pkg::ISSUE: begin
                    if (l15_ack) begin
                        state   <= tinyrv2_l15_pkg::WAIT_RESP;
                        l15_val <= 1'b0;
                    end
                end
                tinyrv2_l15_pkg::WAIT_RESP: begin
                    if (resp_arrive) begin
                        state        <= tinyrv2_l15_pkg::RESPOND;
                        imemresp_val <= (cur_port == tinyrv2_l15_pkg::INSN_PORT);
                        dmemresp_val <= (cur_port == tinyrv2_l15_pkg::DATA_PORT);
                    end
                end
                // hold the response under back-pressure
                tinyrv2_l15_pkg::RESPOND: begin
                    if (resp_done) begin
                        state        <= tinyrv2_l15_pkg::READY;
                        imemresp_val <= 1'b0;
                        dmemresp_val <= 1'b0;
                        imemreq_rdy  <= 1'b1;
                        dmemreq_rdy  <= 1'b1;
                    end
                end
                default: begin
                    state <= tinyrv2_l15_pkg::SLEEP;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* tinyrv2_l15_req_encoder.sv */
// --------------------
// captures the accepted core request and encodes
// the L1.5 request fields from it
// --------------------
`default_nettype none

module tinyrv2_l15_req_encoder (
    input  logic                                      clk,
    input  logic                                      rst_n,

    input  logic                                      capture_en,
    input  tinyrv2_l15_pkg::port_sel_e                capture_sel,
    input  logic [tinyrv2_l15_pkg::REQ_MSG_W-1:0]     imemreq_msg,
    input  logic [tinyrv2_l15_pkg::REQ_MSG_W-1:0]     dmemreq_msg,

    // L1.5 request fields, valid while l15_val is high
    output tinyrv2_l15_pkg::l15_rqtype_e              l15_rqtype,
    output tinyrv2_l15_pkg::pcx_size_e                l15_size,
    output logic [tinyrv2_l15_pkg::PHY_ADDR_W-1:0]    l15_address,
    output logic [63:0]                               l15_data,
    output logic                                      l15_nc,

    // request info the response formatter needs
    output tinyrv2_l15_pkg::mem_len_e                 req_len,
    output logic [3:0]                                req_offset
);

    logic [tinyrv2_l15_pkg::REQ_MSG_W-1:0] req_q;
    logic [31:0] req_addr;
    logic [31:0] req_data;
    logic        req_store;
    logic [31:0] st_data;

    // latch the message on the accept edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_q <= '0;
        end else if (capture_en) begin
            if (capture_sel == tinyrv2_l15_pkg::DATA_PORT) begin
                req_q <= dmemreq_msg;
            end else begin
                req_q <= imemreq_msg;
            end
        end
    end

    assign req_store = req_q[tinyrv2_l15_pkg::REQ_TYPE_BIT];
    assign req_addr  = req_q[tinyrv2_l15_pkg::REQ_ADDR_HI:tinyrv2_l15_pkg::REQ_ADDR_LO];
    assign req_data  = req_q[31:0];
    assign req_len   = tinyrv2_l15_pkg::mem_len_e'(
                           req_q[tinyrv2_l15_pkg::REQ_LEN_HI:tinyrv2_l15_pkg::REQ_LEN_LO]);

    // byte offset within the 16-byte return line
    assign req_offset = req_addr[3:0];

    // upper half of the space is io, sign extend into the 40-bit space
    assign l15_address = {{(tinyrv2_l15_pkg::PHY_ADDR_W - 32){req_addr[31]}}, req_addr};
    assign l15_nc      = req_addr[31];

    // same word on both halves so any lane sees it
    assign l15_data = {st_data, st_data};

    always_comb begin
        l15_rqtype = tinyrv2_l15_pkg::LOAD_RQ;
        l15_size   = tinyrv2_l15_pkg::SZ_4B;
        st_data    = 32'h0;
        if (req_store) begin
            l15_rqtype = tinyrv2_l15_pkg::STORE_RQ;
            case (req_len)
                tinyrv2_l15_pkg::HALF: begin
                    l15_size = tinyrv2_l15_pkg::SZ_2B;
                    st_data  = {2{req_data[7:0], req_data[15:8]}};
                end
                tinyrv2_l15_pkg::BYTE: begin
                    l15_size = tinyrv2_l15_pkg::SZ_1B;
                    st_data  = {4{req_data[7:0]}};
                end
                // word, and the unused len code treated as a word
                default: begin
                    st_data = tinyrv2_l15_pkg::bswap32(req_data);
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* tinyrv2_l15_resp_decoder.sv */
// --------------------
// classifies L1.5 returns, formats the selected lane
// and registers the core response message
// --------------------
`default_nettype none

module tinyrv2_l15_resp_decoder (
    input  logic                                      clk,
    input  logic                                      rst_n,

    // L1.5 return
    input  logic                                      l15_ret_val,
    input  tinyrv2_l15_pkg::l15_rettype_e             l15_rettype,
    input  logic [63:0]                               l15_data_0,
    input  logic [63:0]                               l15_data_1,

    // from controller and encoder
    input  logic                                      resp_load,
    input  tinyrv2_l15_pkg::port_sel_e                cur_port,
    input  tinyrv2_l15_pkg::mem_len_e                 req_len,
    input  logic [3:0]                                req_offset,

    output logic                                      resp_arrive,
    output logic                                      wakeup,
    output logic [tinyrv2_l15_pkg::RESP_MSG_W-1:0]    resp_msg
);

    logic        is_load_ret;
    logic        is_st_ack;
    logic [31:0] lane;
    logic [15:0] lane_half;
    logic [7:0]  lane_byte;
    logic [31:0] fmt_data;

    assign is_load_ret = l15_ret_val && (l15_rettype == tinyrv2_l15_pkg::LOAD_RET);
    assign is_st_ack   = l15_ret_val && (l15_rettype == tinyrv2_l15_pkg::ST_ACK);
    assign resp_arrive = is_load_ret || is_st_ack;

    // other interrupt codes are ignored
    assign wakeup = l15_ret_val && (l15_rettype == tinyrv2_l15_pkg::INT_RET) &&
                    (l15_data_0[17:16] == tinyrv2_l15_pkg::WAKEUP_CODE);

    // lanes are numbered big endian across the two return words
    always_comb begin
        case (req_offset[3:2])
            2'd0:    lane = l15_data_0[63:32];
            2'd1:    lane = l15_data_0[31:0];
            2'd2:    lane = l15_data_1[63:32];
            default: lane = l15_data_1[31:0];
        endcase
    end

    // big endian half at offset bit 1
    assign lane_half = req_offset[1] ? lane[15:0] : lane[31:16];

    // byte n sits at bits 31-8n, so shift by 8*(3-n)
    assign lane_byte = 8'(lane >> {~req_offset[1:0], 3'b000});

    always_comb begin
        if (is_st_ack) begin
            fmt_data = 32'h0;
        end else if (cur_port == tinyrv2_l15_pkg::INSN_PORT) begin
            // fetches are always whole words
            fmt_data = tinyrv2_l15_pkg::bswap32(lane);
        end else begin
            case (req_len)
                tinyrv2_l15_pkg::HALF: fmt_data = {2{lane_half[7:0], lane_half[15:8]}};
                tinyrv2_l15_pkg::BYTE: fmt_data = {4{lane_byte}};
                default:               fmt_data = tinyrv2_l15_pkg::bswap32(lane);
            endcase
        end
    end

    // one message shared by both ports, held until the core takes it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_msg <= {1'b0, tinyrv2_l15_pkg::WORD, tinyrv2_l15_pkg::NOP_INSN};
        end else if (resp_load) begin
            resp_msg <= {is_st_ack, req_len, fmt_data};
        end
    end

endmodule

`default_nettype wire

/* tinyrv2_l15_bridge.sv */
// --------------------
// tinyrv2 imem/dmem to L1.5 bridge top, instantiate
// this between the core memory ports and the L1.5
// --------------------
`default_nettype none

module tinyrv2_l15_bridge (
    input  logic                                      clk,
    input  logic                                      rst_n,

    // core instruction port
    input  logic [tinyrv2_l15_pkg::REQ_MSG_W-1:0]     imemreq_msg,
    input  logic                                      imemreq_val,
    output logic                                      imemreq_rdy,
    output logic [tinyrv2_l15_pkg::RESP_MSG_W-1:0]    imemresp_msg,
    output logic                                      imemresp_val,
    input  logic                                      imemresp_rdy,

    // core data port
    input  logic [tinyrv2_l15_pkg::REQ_MSG_W-1:0]     dmemreq_msg,
    input  logic                                      dmemreq_val,
    output logic                                      dmemreq_rdy,
    output logic [tinyrv2_l15_pkg::RESP_MSG_W-1:0]    dmemresp_msg,
    output logic                                      dmemresp_val,
    input  logic                                      dmemresp_rdy,

    // L1.5 request
    output tinyrv2_l15_pkg::l15_rqtype_e              l15_rqtype,
    output tinyrv2_l15_pkg::pcx_size_e                l15_size,
    output logic                                      l15_val,
    output logic [tinyrv2_l15_pkg::PHY_ADDR_W-1:0]    l15_address,
    output logic [63:0]                               l15_data,
    output logic                                      l15_nc,
    input  logic                                      l15_ack,

    // L1.5 return
    input  logic                                      l15_ret_val,
    input  tinyrv2_l15_pkg::l15_rettype_e             l15_rettype,
    input  logic [63:0]                               l15_data_0,
    input  logic [63:0]                               l15_data_1
);

    logic                                    capture_en;
    tinyrv2_l15_pkg::port_sel_e              capture_sel;
    logic                                    resp_load;
    tinyrv2_l15_pkg::port_sel_e              cur_port;
    logic                                    resp_arrive;
    logic                                    wakeup;
    tinyrv2_l15_pkg::mem_len_e               req_len;
    logic [3:0]                              req_offset;
    logic [tinyrv2_l15_pkg::RESP_MSG_W-1:0]  resp_msg;

    tinyrv2_l15_ctrl u_tinyrv2_l15_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .imemreq_val  (imemreq_val),
        .dmemreq_val  (dmemreq_val),
        .imemresp_rdy (imemresp_rdy),
        .dmemresp_rdy (dmemresp_rdy),
        .imemreq_rdy  (imemreq_rdy),
        .dmemreq_rdy  (dmemreq_rdy),
        .imemresp_val (imemresp_val),
        .dmemresp_val (dmemresp_val),
        .l15_ack      (l15_ack),
        .l15_val      (l15_val),
        .resp_arrive  (resp_arrive),
        .wakeup       (wakeup),
        .capture_en   (capture_en),
        .capture_sel  (capture_sel),
        .resp_load    (resp_load),
        .cur_port     (cur_port)
    );

    tinyrv2_l15_req_encoder u_tinyrv2_l15_req_encoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .capture_en  (capture_en),
        .capture_sel (capture_sel),
        .imemreq_msg (imemreq_msg),
        .dmemreq_msg (dmemreq_msg),
        .l15_rqtype  (l15_rqtype),
        .l15_size    (l15_size),
        .l15_address (l15_address),
        .l15_data    (l15_data),
        .l15_nc      (l15_nc),
        .req_len     (req_len),
        .req_offset  (req_offset)
    );

    tinyrv2_l15_resp_decoder u_tinyrv2_l15_resp_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .l15_ret_val (l15_ret_val),
        .l15_rettype (l15_rettype),
        .l15_data_0  (l15_data_0),
        .l15_data_1  (l15_data_1),
        .resp_load   (resp_load),
        .cur_port    (cur_port),
        .req_len     (req_len),
        .req_offset  (req_offset),
        .resp_arrive (resp_arrive),
        .wakeup      (wakeup),
        .resp_msg    (resp_msg)
    );

    // the valids tell the ports apart
    assign imemresp_msg = resp_msg;
    assign dmemresp_msg = resp_msg;

endmodule

`default_nettype wire

/* tinyrv2_l15_bridge_tb.sv */
// --------------------
// self-checking testbench for the bridge, drives both core ports
// and plays the L1.5 with random ack and return delays
// --------------------
`default_nettype none

module tinyrv2_l15_bridge_tb;

    localparam int WAIT_LIMIT = 200;

    logic                                   clk;
    logic                                   rst_n;
    logic [tinyrv2_l15_pkg::REQ_MSG_W-1:0]  imemreq_msg;
    logic                                   imemreq_val;
    logic                                   imemreq_rdy;
    logic [tinyrv2_l15_pkg::RESP_MSG_W-1:0] imemresp_msg;
    logic                                   imemresp_val;
    logic                                   imemresp_rdy;
    logic [tinyrv2_l15_pkg::REQ_MSG_W-1:0]  dmemreq_msg;
    logic                                   dmemreq_val;
    logic                                   dmemreq_rdy;
    logic [tinyrv2_l15_pkg::RESP_MSG_W-1:0] dmemresp_msg;
    logic                                   dmemresp_val;
    logic                                   dmemresp_rdy;
    tinyrv2_l15_pkg::l15_rqtype_e           l15_rqtype;
    tinyrv2_l15_pkg::pcx_size_e             l15_size;
    logic                                   l15_val;
    logic [tinyrv2_l15_pkg::PHY_ADDR_W-1:0] l15_address;
    logic [63:0]                            l15_data;
    logic                                   l15_nc;
    logic                                   l15_ack;
    logic                                   l15_ret_val;
    tinyrv2_l15_pkg::l15_rettype_e          l15_rettype;
    logic [63:0]                            l15_data_0;
    logic [63:0]                            l15_data_1;

    logic [31:0] rng;
    int          mismatches;
    int          failures;

    tinyrv2_l15_bridge u_tinyrv2_l15_bridge (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] rand32();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic logic [31:0] reverse_bytes(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // big endian store word, sub-word data repeated across it
    function automatic logic [31:0] encode_store(input logic [1:0] len, input logic [31:0] d);
        case (len)
            2'd1:    return {4{d[7:0]}};
            2'd2:    return {2{d[7:0], d[15:8]}};
            default: return reverse_bytes(d);
        endcase
    endfunction

    // loads always ask for 4 bytes
    function automatic logic [2:0] size_code(input logic is_store, input logic [1:0] len);
        if (!is_store || len == 2'd0) begin
            return 3'd2;
        end
        return (len == 2'd2) ? 3'd1 : 3'd0;
    endfunction

    // lane 0 is the top of data_0, lane 3 the bottom of data_1
    function automatic logic [31:0] load_result(input logic is_insn, input logic [1:0] len,
            input logic [3:0] off, input logic [63:0] d0, input logic [63:0] d1);
        logic [127:0] line;
        logic [31:0]  lane;
        logic [15:0]  half;
        logic [7:0]   b;
        line = {d0, d1};
        lane = line[127 - 32 * int'(off[3:2]) -: 32];
        half = lane[31 - 16 * int'(off[1]) -: 16];
        b    = lane[31 - 8 * int'(off[1:0]) -: 8];
        if (is_insn || len == 2'd0) begin
            return reverse_bytes(lane);
        end
        if (len == 2'd2) begin
            return {2{half[7:0], half[15:8]}};
        end
        return {4{b}};
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            mismatches++;
            $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_timeout(input string what);
        failures++;
        $display("timed out waiting for %s at %0t", what, $time);
    endtask

    // request fields while l15_val is up, core side blocked
    task automatic check_request(input logic is_store, input logic [31:0] addr,
                                 input logic [1:0] len, input logic [31:0] data);
        logic [31:0] w;
        w = is_store ? encode_store(len, data) : 32'h0;
        check_value("l15_val", l15_val, 1'b1);
        check_value("l15_rqtype", l15_rqtype,
                    is_store ? tinyrv2_l15_pkg::STORE_RQ : tinyrv2_l15_pkg::LOAD_RQ);
        check_value("l15_size", l15_size, size_code(is_store, len));
        check_value("l15_address", l15_address, {{8{addr[31]}}, addr});
        check_value("l15_nc", l15_nc, addr[31]);
        check_value("l15_data", l15_data, {w, w});
        check_value("imemreq_rdy", imemreq_rdy, 1'b0);
        check_value("dmemreq_rdy", dmemreq_rdy, 1'b0);
    endtask

    // one cycle return strobe, ends on the negedge after it was sampled
    task automatic send_return(input tinyrv2_l15_pkg::l15_rettype_e rtype,
                               input logic [63:0] d0, input logic [63:0] d1);
        @(posedge clk);
        l15_ret_val <= 1'b1;
        l15_rettype <= rtype;
        l15_data_0  <= d0;
        l15_data_1  <= d1;
        @(posedge clk);
        l15_ret_val <= 1'b0;
        @(negedge clk);
    endtask

    task automatic raise_request(input logic is_insn, input logic [66:0] msg);
        @(posedge clk);
        if (is_insn) begin
            imemreq_val <= 1'b1;
            imemreq_msg <= msg;
        end else begin
            dmemreq_val <= 1'b1;
            dmemreq_msg <= msg;
        end
        @(negedge clk);
    endtask

    // accept, cache handshake, return and core response for one raised request
    task automatic run_transaction(input logic is_insn, input logic [66:0] msg);
        logic                          is_store;
        logic [31:0]                   addr;
        logic [1:0]                    len;
        logic [63:0]                   d0;
        logic [63:0]                   d1;
        logic [34:0]                   exp_msg;
        tinyrv2_l15_pkg::l15_rettype_e rtype;
        int                            n;
        int                            hold;
        is_store = msg[tinyrv2_l15_pkg::REQ_TYPE_BIT];
        addr     = msg[tinyrv2_l15_pkg::REQ_ADDR_HI:tinyrv2_l15_pkg::REQ_ADDR_LO];
        len      = msg[tinyrv2_l15_pkg::REQ_LEN_HI:tinyrv2_l15_pkg::REQ_LEN_LO];
        d0       = {rand32(), rand32()};
        d1       = {rand32(), rand32()};
        rtype    = is_store ? tinyrv2_l15_pkg::ST_ACK : tinyrv2_l15_pkg::LOAD_RET;
        n = 0;
        while (!(is_insn ? imemreq_rdy : dmemreq_rdy) && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!(is_insn ? imemreq_rdy : dmemreq_rdy)) begin
            report_timeout("request ready");
        end
        // rdy seen high, so this edge takes the request
        @(posedge clk);
        if (is_insn) begin
            imemreq_val <= 1'b0;
        end else begin
            dmemreq_val <= 1'b0;
        end
        // cache sits on the request for a while before the ack
        hold = rand32() % 4;
        repeat (hold + 1) begin
            @(negedge clk);
            check_request(is_store, addr, len, msg[31:0]);
        end
        @(posedge clk);
        l15_ack <= 1'b1;
        @(negedge clk);
        check_request(is_store, addr, len, msg[31:0]);
        @(posedge clk);
        l15_ack <= 1'b0;
        @(negedge clk);
        check_value("l15_val", l15_val, 1'b0);
        // still busy while the return is outstanding
        check_value("imemreq_rdy", imemreq_rdy, 1'b0);
        check_value("dmemreq_rdy", dmemreq_rdy, 1'b0);
        repeat (rand32() % 3) @(negedge clk);
        send_return(rtype, d0, d1);
        n = 0;
        while (!(imemresp_val || dmemresp_val) && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!(imemresp_val || dmemresp_val)) begin
            report_timeout("response valid");
        end
        exp_msg = {is_store, len,
                   is_store ? 32'h0 : load_result(is_insn, len, addr[3:0], d0, d1)};
        // back-pressure, valid and message hold still
        hold = rand32() % 6;
        repeat (hold + 1) begin
            check_value("imemresp_val", imemresp_val, is_insn);
            check_value("dmemresp_val", dmemresp_val, !is_insn);
            check_value(is_insn ? "imemresp_msg" : "dmemresp_msg",
                        is_insn ? imemresp_msg : dmemresp_msg, exp_msg);
            check_value("imemreq_rdy", imemreq_rdy, 1'b0);
            check_value("dmemreq_rdy", dmemreq_rdy, 1'b0);
            @(negedge clk);
        end
        @(posedge clk);
        imemresp_rdy <= is_insn;
        dmemresp_rdy <= !is_insn;
        @(posedge clk);
        imemresp_rdy <= 1'b0;
        dmemresp_rdy <= 1'b0;
        @(negedge clk);
        check_value("imemresp_val", imemresp_val, 1'b0);
        check_value("dmemresp_val", dmemresp_val, 1'b0);
        check_value("imemreq_rdy", imemreq_rdy, 1'b1);
        check_value("dmemreq_rdy", dmemreq_rdy, 1'b1);
    endtask

    initial begin
        logic [66:0] im;
        logic [66:0] dm;
        logic [63:0] d0;
        logic [31:0] a;
        rng          = 32'hd2c8_7faa;
        mismatches   = 0;
        failures     = 0;
        clk          = 1'b0;
        rst_n        <= 1'b0;
        imemreq_msg  <= '0;
        imemreq_val  <= 1'b0;
        imemresp_rdy <= 1'b0;
        dmemreq_msg  <= '0;
        dmemreq_val  <= 1'b0;
        dmemresp_rdy <= 1'b0;
        l15_ack      <= 1'b0;
        l15_ret_val  <= 1'b0;
        l15_rettype  <= tinyrv2_l15_pkg::LOAD_RET;
        l15_data_0   <= '0;
        l15_data_1   <= '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        // asleep after reset
        check_value("imemreq_rdy", imemreq_rdy, 1'b0);
        check_value("dmemreq_rdy", dmemreq_rdy, 1'b0);
        check_value("l15_val", l15_val, 1'b0);
        check_value("imemresp_val", imemresp_val, 1'b0);
        check_value("dmemresp_val", dmemresp_val, 1'b0);
        // reset message is a word nop
        check_value("imemresp_msg", imemresp_msg, {1'b0, 2'd0, 32'h0000_0013});
        // wrong interrupt code keeps it asleep
        d0 = {rand32(), rand32()};
        d0[17:16] = 2'd2;
        send_return(tinyrv2_l15_pkg::INT_RET, d0, 64'h0);
        check_value("imemreq_rdy", imemreq_rdy, 1'b0);
        check_value("dmemreq_rdy", dmemreq_rdy, 1'b0);
        d0[17:16] = tinyrv2_l15_pkg::WAKEUP_CODE;
        send_return(tinyrv2_l15_pkg::INT_RET, d0, 64'h0);
        check_value("imemreq_rdy", imemreq_rdy, 1'b1);
        check_value("dmemreq_rdy", dmemreq_rdy, 1'b1);
        for (int i = 0; i < 9; i++) begin
            dm = {1'b1, rand32(), 2'(i % 3), rand32()};
            raise_request(1'b0, dm);
            run_transaction(1'b0, dm);
        end
        // every offset against every len
        for (int i = 0; i < 48; i++) begin
            a = rand32();
            a[3:0] = 4'(i);
            dm = {1'b0, a, 2'(i % 3), rand32()};
            raise_request(1'b0, dm);
            run_transaction(1'b0, dm);
        end
        // fetches come back as whole words whatever len says
        for (int i = 0; i < 4; i++) begin
            im = {1'b0, rand32(), 2'(i % 3), 32'h0};
            raise_request(1'b1, im);
            run_transaction(1'b1, im);
        end
        // both ports valid together, data first and fetch right after
        for (int i = 0; i < 3; i++) begin
            im = {1'b0, rand32(), 2'd0, 32'h0};
            dm = {1'(rand32()), rand32(), 2'(rand32() % 3), rand32()};
            @(posedge clk);
            imemreq_val <= 1'b1;
            imemreq_msg <= im;
            dmemreq_val <= 1'b1;
            dmemreq_msg <= dm;
            @(negedge clk);
            run_transaction(1'b0, dm);
            run_transaction(1'b1, im);
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tinyrv2_l15_bridge.f */
tinyrv2_l15_pkg.sv
tinyrv2_l15_ctrl.sv
tinyrv2_l15_req_encoder.sv
tinyrv2_l15_resp_decoder.sv
tinyrv2_l15_bridge.sv
tinyrv2_l15_bridge_tb.sv

/* Bender.yml */
package:
  name: tinyrv2_l15_bridge

sources:
  - tinyrv2_l15_pkg.sv
  - tinyrv2_l15_ctrl.sv
  - tinyrv2_l15_req_encoder.sv
  - tinyrv2_l15_resp_decoder.sv
  - tinyrv2_l15_bridge.sv
  - target: test
    files:
      - tinyrv2_l15_bridge_tb.sv
